/* logic/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // Physical register id width, bounds the register file depth
    localparam int PRF_ID_W = 6;

    localparam int ROB_ID_W = 5;

    localparam int UOP_W = 5;

    typedef logic [XLEN-1:0]     t_data;
    typedef logic [XLEN-1:0]     t_paddr;
    typedef logic [PRF_ID_W-1:0] t_prf_id;
    typedef logic [ROB_ID_W-1:0] t_rob_id;

    // Integer micro-ops, unlisted codes are illegal
    typedef enum logic [UOP_W-1:0] {
        U_ADD  = 5'd0,
        U_SUB  = 5'd1,
        U_AND  = 5'd2,
        U_OR   = 5'd3,
        U_XOR  = 5'd4,
        U_SLL  = 5'd5,
        U_SRL  = 5'd6,
        U_SLT  = 5'd7,
        U_SLTU = 5'd8,
        U_BEQ  = 5'd9,
        U_BNE  = 5'd10,
        U_BLT  = 5'd11,
        U_BGE  = 5'd12,
        U_JAL  = 5'd13
    } t_uop;

    // Branches and jumps, handled by the branch unit
    function automatic logic f_is_branch(t_uop uop);
        logic is_br;
        is_br = 1'b0;
        case (uop)
            U_BEQ, U_BNE, U_BLT, U_BGE, U_JAL: is_br = 1'b1;
            default: is_br = 1'b0;
        endcase
        return is_br;
    endfunction

endpackage

`default_nettype wire

/* logic/iprf.sv */
`timescale 1ns/1ps
`default_nettype none

module iprf
    import exe_pkg::*;
#(
    parameter int NUM_PREGS = 64
) (
    input  logic    clk,
    input  logic    rst,
    input  t_prf_id rd1_id,
    input  t_prf_id rd2_id,
    output t_data   rd1_data,
    output t_data   rd2_data,
    input  logic    wr_en,
    input  t_prf_id wr_id,
    input  t_data   wr_data
);

    t_data regs [NUM_PREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (int'(wr_id) < NUM_PREGS)) begin
            regs[wr_id] <= wr_data;
        end
    end

    // Same-cycle write bypasses the array
    always_comb begin
        rd1_data = '0;
        rd2_data = '0;
        if (wr_en && (wr_id == rd1_id)) begin
            rd1_data = wr_data;
        end else if (int'(rd1_id) < NUM_PREGS) begin
            rd1_data = regs[rd1_id];
        end
        if (wr_en && (wr_id == rd2_id)) begin
            rd2_data = wr_data;
        end else if (int'(rd2_id) < NUM_PREGS) begin
            rd2_data = regs[rd2_id];
        end
    end

endmodule

`default_nettype wire

/* logic/ialu.sv */
`timescale 1ns/1ps
`default_nettype none

module ialu
    import exe_pkg::*;
(
    input  t_uop  uop,
    input  t_data src1,
    input  t_data src2,
    output logic  resvld,
    output t_data result
);

    logic [4:0] shamt;
    logic       known;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        known  = 1'b1;
        result = '0;
        case (uop)
            U_ADD: begin
                result = src1 + src2;
            end
            U_SUB: begin
                result = src1 - src2;
            end
            U_AND: begin
                result = src1 & src2;
            end
            U_OR: begin
                result = src1 | src2;
            end
            U_XOR: begin
                result = src1 ^ src2;
            end
            U_SLL: begin
                result = src1 << shamt;
            end
            U_SRL: begin
                result = src1 >> shamt;
            end
            U_SLT: begin
                result = XLEN'(lt_signed);
            end
            U_SLTU: begin
                result = XLEN'(lt_unsigned);
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign resvld = known && !f_is_branch(uop);

endmodule

`default_nettype wire

/* logic/ibr.sv */
`timescale 1ns/1ps
`default_nettype none

module ibr
    import exe_pkg::*;
(
    input  logic   iss,
    input  t_uop   uop,
    input  t_data  src1,
    input  t_data  src2,
    input  t_paddr pc,
    input  t_paddr imm,
    output logic   resvld,
    output t_data  result,
    output logic   mispred,
    output t_paddr mispred_tgt
);

    logic is_br;
    logic taken;
    logic eq;
    logic lt;

    assign is_br = f_is_branch(uop);
    assign eq    = src1 == src2;
    assign lt    = $signed(src1) < $signed(src2);

    // Condition evaluation
    always_comb begin
        case (uop)
            U_BEQ: begin
                taken = eq;
            end
            U_BNE: begin
                taken = !eq;
            end
            U_BLT: begin
                taken = lt;
            end
            U_BGE: begin
                taken = !lt;
            end
            U_JAL: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // Link value
    assign resvld = is_br;
    assign result = is_br ? t_data'(pc + t_paddr'(4)) : '0;

    // Predicted not taken, so every taken branch redirects
    assign mispred     = iss && is_br && taken;
    assign mispred_tgt = pc + imm;

endmodule

`default_nettype wire

/* logic/exe.sv */
`timescale 1ns/1ps
`default_nettype none

module exe
    import exe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    iss,
    input  logic    nuke,
    input  t_uop    uop,
    input  t_data   rs1_data,
    input  t_data   rs2_data,
    input  logic    src2_imm,
    input  t_paddr  imm,
    input  t_paddr  pc,
    input  logic    dst_vld,
    input  t_prf_id pdst,
    input  t_rob_id robid,
    output logic    mispred,
    output t_paddr  mispred_tgt,
    output t_rob_id mispred_robid,
    output logic    wr_en,
    output t_prf_id wr_pdst,
    output t_data   wr_data,
    output logic    cmpl,
    output t_rob_id cmpl_robid,
    output logic    cmpl_mispred
);

    t_data   src2;
    logic    ialu_resvld;
    t_data   ialu_result;
    logic    ibr_resvld;
    t_data   ibr_result;
    t_data   result_ex0;

    logic    vld_ex1;
    logic    dst_vld_ex1;
    logic    mispred_ex1;
    t_prf_id pdst_ex1;
    t_rob_id robid_ex1;
    t_data   result_ex1;

    // EX0
    assign src2 = src2_imm ? t_data'(imm) : rs2_data;

    ialu ialu_inst (
        .uop    (uop),
        .src1   (rs1_data),
        .src2   (src2),
        .resvld (ialu_resvld),
        .result (ialu_result)
    );

    ibr ibr_inst (
        .iss         (iss),
        .uop         (uop),
        .src1        (rs1_data),
        .src2        (src2),
        .pc          (pc),
        .imm         (imm),
        .resvld      (ibr_resvld),
        .result      (ibr_result),
        .mispred     (mispred),
        .mispred_tgt (mispred_tgt)
    );

    assign mispred_robid = robid;

    // Illegal uops fall through to zero
    assign result_ex0 = ialu_resvld ? ialu_result :
                        ibr_resvld  ? ibr_result  : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_ex1     <= 1'b0;
            dst_vld_ex1 <= 1'b0;
            mispred_ex1 <= 1'b0;
        end else begin
            vld_ex1     <= iss;
            dst_vld_ex1 <= iss && dst_vld;
            mispred_ex1 <= mispred;
        end
    end

    always_ff @(posedge clk) begin
        pdst_ex1   <= pdst;
        robid_ex1  <= robid;
        result_ex1 <= result_ex0;
    end

    // Flush in EX1 cancels write-back and completion
    assign wr_en        = dst_vld_ex1 && !nuke;
    assign wr_pdst      = pdst_ex1;
    assign wr_data      = result_ex1;
    assign cmpl         = vld_ex1 && !nuke;
    assign cmpl_robid   = robid_ex1;
    assign cmpl_mispred = mispred_ex1;

endmodule

`default_nettype wire

/* logic/exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_core
    import exe_pkg::*;
#(
    parameter int NUM_PREGS = 64
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    iss,
    input  t_uop    uop,
    input  t_prf_id psrc1,
    input  t_prf_id psrc2,
    input  logic    src2_imm,
    input  t_paddr  imm,
    input  t_paddr  pc,
    input  logic    dst_vld,
    input  t_prf_id pdst,
    input  t_rob_id robid,
    input  logic    nuke,
    output logic    mispred,
    output t_paddr  mispred_tgt,
    output t_rob_id mispred_robid,
    output logic    wr_en,
    output t_prf_id wr_pdst,
    output t_data   wr_data,
    output logic    cmpl,
    output t_rob_id cmpl_robid,
    output logic    cmpl_mispred
);

    t_data rd1_data;
    t_data rd2_data;

    iprf #(
        .NUM_PREGS (NUM_PREGS)
    ) iprf_inst (
        .clk      (clk),
        .rst      (rst),
        .rd1_id   (psrc1),
        .rd2_id   (psrc2),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .wr_en    (wr_en),
        .wr_id    (wr_pdst),
        .wr_data  (wr_data)
    );

    exe exe_inst (
        .clk           (clk),
        .rst           (rst),
        .iss           (iss),
        .nuke          (nuke),
        .uop           (uop),
        .rs1_data      (rd1_data),
        .rs2_data      (rd2_data),
        .src2_imm      (src2_imm),
        .imm           (imm),
        .pc            (pc),
        .dst_vld       (dst_vld),
        .pdst          (pdst),
        .robid         (robid),
        .mispred       (mispred),
        .mispred_tgt   (mispred_tgt),
        .mispred_robid (mispred_robid),
        .wr_en         (wr_en),
        .wr_pdst       (wr_pdst),
        .wr_data       (wr_data),
        .cmpl          (cmpl),
        .cmpl_robid    (cmpl_robid),
        .cmpl_mispred  (cmpl_mispred)
    );

endmodule

`default_nettype wire

/* tests/exe_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_props (
    input logic clk,
    input logic rst,
    input logic iss,
    input logic ialu_resvld,
    input logic ibr_resvld,
    input logic wr_en,
    input logic cmpl
);

    // One unit claims each micro-op
    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(ialu_resvld && ibr_resvld))
        else $error("both execution units flagged a valid result");

    a_wr_needs_cmpl: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> cmpl)
        else $error("write-back without completion");

    // Empty EX1 retires nothing
    a_idle_no_retire: assert property (@(posedge clk) disable iff (rst)
        !iss |=> !cmpl && !wr_en)
        else $error("completion or write-back one cycle after an idle cycle");

endmodule

bind exe exe_props exe_props_inst (
    .clk         (clk),
    .rst         (rst),
    .iss         (iss),
    .ialu_resvld (ialu_resvld),
    .ibr_resvld  (ibr_resvld),
    .wr_en       (wr_en),
    .cmpl        (cmpl)
);

`default_nettype wire

/* tests/exe_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_core_tb
    import exe_pkg::*;
();

    localparam int NUM_PREGS = 64;
    localparam int NUM_UOPS  = 2000;
    // 2000 issues at a 7 in 8 issue rate take about 2300 cycles
    localparam int TIMEOUT_CYC = 3000;

    logic    clk;
    logic    rst;
    logic    iss;
    t_uop    uop;
    t_prf_id psrc1;
    t_prf_id psrc2;
    logic    src2_imm;
    t_paddr  imm;
    t_paddr  pc;
    logic    dst_vld;
    t_prf_id pdst;
    t_rob_id robid;
    logic    nuke;
    logic    mispred;
    t_paddr  mispred_tgt;
    t_rob_id mispred_robid;
    logic    wr_en;
    t_prf_id wr_pdst;
    t_data   wr_data;
    logic    cmpl;
    t_rob_id cmpl_robid;
    logic    cmpl_mispred;

    // Reference state, one register file and one EX1 entry
    t_data       model_regs [NUM_PREGS];
    logic        pend_vld;
    logic        pend_dst_vld;
    t_prf_id     pend_pdst;
    t_rob_id     pend_robid;
    t_data       pend_data;
    logic        pend_mispred;
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          issued = 0;
    int          n_taken = 0;
    int          n_nuked = 0;
    int          n_fwd = 0;

    exe_core #(
        .NUM_PREGS (NUM_PREGS)
    ) exe_core_inst (
        .clk           (clk),
        .rst           (rst),
        .iss           (iss),
        .uop           (uop),
        .psrc1         (psrc1),
        .psrc2         (psrc2),
        .src2_imm      (src2_imm),
        .imm           (imm),
        .pc            (pc),
        .dst_vld       (dst_vld),
        .pdst          (pdst),
        .robid         (robid),
        .nuke          (nuke),
        .mispred       (mispred),
        .mispred_tgt   (mispred_tgt),
        .mispred_robid (mispred_robid),
        .wr_en         (wr_en),
        .wr_pdst       (wr_pdst),
        .wr_data       (wr_data),
        .cmpl          (cmpl),
        .cmpl_robid    (cmpl_robid),
        .cmpl_mispred  (cmpl_mispred)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            stop_with_error("timeout, the micro-op stream did not finish in time");
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input t_data got, input t_data exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_paddr(input string name, input t_paddr got, input t_paddr exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    // Also used for ROB ids, zero-extended
    task automatic check_id(input string name, input t_prf_id got, input t_prf_id exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = rand16();
        lo = rand16();
        return {hi, lo};
    endfunction

    function automatic t_data uop_result(t_uop op, t_data a, t_data b, t_paddr pc_v);
        case (op)
            U_ADD:  return a + b;
            U_SUB:  return a - b;
            U_AND:  return a & b;
            U_OR:   return a | b;
            U_XOR:  return a ^ b;
            U_SLL:  return a << b[4:0];
            U_SRL:  return a >> b[4:0];
            U_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            U_SLTU: return (a < b) ? 32'd1 : 32'd0;
            // Link value
            U_BEQ, U_BNE, U_BLT, U_BGE, U_JAL: return pc_v + 32'd4;
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(t_uop op, t_data a, t_data b);
        case (op)
            U_BEQ:   return a == b;
            U_BNE:   return a != b;
            U_BLT:   return $signed(a) < $signed(b);
            U_BGE:   return $signed(a) >= $signed(b);
            U_JAL:   return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic drive_random();
        logic [15:0] r;
        logic [31:0] w;
        r        = rand16();
        iss      = (r[2:0] != 3'd0);
        nuke     = (r[7:4] == 4'd0);
        uop      = t_uop'({1'b0, r[12:9]});
        src2_imm = r[13];
        dst_vld  = (r[15:14] != 2'd0);
        r        = rand16();
        // Only 8 registers, so dependencies are frequent
        psrc1    = {3'b000, r[2:0]};
        psrc2    = {3'b000, r[5:3]};
        pdst     = {3'b000, r[8:6]};
        robid    = r[13:9];
        w        = rand32();
        imm      = r[14] ? w : {24'h0, w[7:0]};
        w        = rand32();
        pc       = {w[31:2], 2'b00};
    endtask

    task automatic check_and_model();
        logic  exp_cmpl;
        logic  exp_wr;
        logic  exp_mp;
        t_data a;
        t_data b;
        exp_cmpl = pend_vld && !nuke;
        exp_wr   = exp_cmpl && pend_dst_vld;
        check_bit("cmpl", cmpl, exp_cmpl);
        check_bit("wr_en", wr_en, exp_wr);
        if (exp_cmpl) begin
            check_id("cmpl_robid", {1'b0, cmpl_robid}, {1'b0, pend_robid});
            check_bit("cmpl_mispred", cmpl_mispred, pend_mispred);
        end
        if (pend_vld && nuke) begin
            n_nuked++;
        end
        if (exp_wr) begin
            check_id("wr_pdst", wr_pdst, pend_pdst);
            check_data("wr_data", wr_data, pend_data);
            model_regs[pend_pdst] = pend_data;
        end
        // New micro-op reads the file after retirement
        a = model_regs[psrc1];
        b = src2_imm ? imm : model_regs[psrc2];
        if (exp_wr && iss && (pend_pdst == psrc1 || (!src2_imm && pend_pdst == psrc2))) begin
            n_fwd++;
        end
        exp_mp = iss && f_is_branch(uop) && branch_taken(uop, a, b);
        check_bit("mispred", mispred, exp_mp);
        if (exp_mp) begin
            check_paddr("mispred_tgt", mispred_tgt, pc + imm);
            check_id("mispred_robid", {1'b0, mispred_robid}, {1'b0, robid});
            n_taken++;
        end
        pend_vld     = iss;
        pend_dst_vld = dst_vld;
        pend_pdst    = pdst;
        pend_robid   = robid;
        pend_data    = uop_result(uop, a, b, pc);
        pend_mispred = exp_mp;
    endtask

    initial begin
        lcg_state = 32'd12;
        rst       = 1'b1;
        iss       = 1'b0;
        uop       = U_ADD;
        psrc1     = '0;
        psrc2     = '0;
        src2_imm  = 1'b0;
        imm       = '0;
        pc        = '0;
        dst_vld   = 1'b0;
        pdst      = '0;
        robid     = '0;
        nuke      = 1'b0;
        pend_vld  = 1'b0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
            check_bit("wr_en", wr_en, 1'b0);
            check_bit("cmpl", cmpl, 1'b0);
            check_bit("mispred", mispred, 1'b0);
        end
        @(negedge clk);
        rst = 1'b0;
        while (issued < NUM_UOPS) begin
            drive_random();
            if (iss) begin
                issued++;
            end
            #1;
            check_and_model();
            @(negedge clk);
        end
        // Drain the last micro-op from EX1
        iss  = 1'b0;
        nuke = 1'b0;
        #1;
        check_and_model();
        if (n_taken == 0 || n_nuked == 0 || n_fwd == 0) begin
            stop_with_error("the run saw no taken branch, no flush or no forwarded operand");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* exe_core.f */
logic/exe_pkg.sv
logic/iprf.sv
logic/ialu.sv
logic/ibr.sv
logic/exe.sv
logic/exe_core.sv
tests/exe_core_props.sv
tests/exe_core_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exe_core_tb \
    -f exe_core.f -o exe_core_sim

status=0
./obj_dir/exe_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished cleanly"
